// ==== logic/fabric_pkg.sv ====
// memory fabric types and address map
`default_nettype none

package fabric_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;
   localparam int STRB_W = DATA_W / 8;

   // region base addresses
   localparam logic [ADDR_W-1:0] BRAM_BASE = 32'h0000_0000;
   localparam logic [ADDR_W-1:0] DRAM_BASE = 32'h4000_0000;

   typedef enum logic {
      OP_READ,
      OP_WRITE
   } mem_op_e;

   typedef enum logic {
      RESP_OKAY,
      RESP_DECERR
   } resp_status_e;

   // which bank owns a request
   typedef enum logic [1:0] {
      TGT_BRAM,
      TGT_DRAM,
      TGT_NONE
   } mem_target_e;

   typedef struct packed {
      mem_op_e             op;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   wdata;
      logic [STRB_W-1:0]   strb;     // one bit per byte lane
   } mem_req_t;

   typedef struct packed {
      resp_status_e        status;
      logic [DATA_W-1:0]   rdata;    // zero for writes and errors
   } mem_resp_t;

endpackage

`default_nettype wire

// ==== logic/order_fifo.sv ====
// in-order target FIFO
`timescale 1ns/100ps
`default_nettype none

module order_fifo #(
   parameter int DEPTH = 8
) (
   input  wire logic                    mig_clk,
   input  wire logic                    rst_n_i,
   input  wire logic                    push_i,
   input  wire fabric_pkg::mem_target_e target_i,
   output logic                         full_o,
   input  wire logic                    pop_i,
   output fabric_pkg::mem_target_e      head_o,
   output logic                         empty_o
);
   import fabric_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   mem_target_e      slots [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] step(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full_o  = (count == CNT_W'(DEPTH));
   assign empty_o = (count == '0);
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;
   assign head_o  = slots[rd_ptr];   // valid only when not empty

   always_ff @(posedge mig_clk) begin
      if (do_push) begin
         slots[wr_ptr] <= target_i;
      end
   end

   always_ff @(posedge mig_clk) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= step(wr_ptr);
         if (do_pop) rd_ptr <= step(rd_ptr);
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      end
   end

endmodule

`default_nettype wire

// ==== logic/mem_bank.sv ====
// byte-strobed memory bank
`timescale 1ns/100ps
`default_nettype none

module mem_bank #(
   parameter int WORDS   = 256,
   parameter int LATENCY = 1
) (
   input  wire logic                  mig_clk,
   input  wire logic                  rst_n_i,
   input  wire fabric_pkg::mem_req_t  req_i,
   input  wire logic                  req_valid_i,
   output logic                       req_ready_o,
   output fabric_pkg::mem_resp_t      resp_o,
   output logic                       resp_valid_o,
   input  wire logic                  resp_ready_i
);
   import fabric_pkg::*;

   localparam int IDX_W = $clog2(WORDS);
   localparam int PTR_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;
   localparam int CNT_W = $clog2(LATENCY + 1);

   logic [DATA_W-1:0]  ram [WORDS];
   logic [IDX_W-1:0]   idx;
   logic               accept;
   logic               take;

   logic [LATENCY-1:0] pipe_v;              // delay line tags
   mem_op_e            pipe_op   [LATENCY];
   logic [DATA_W-1:0]  pipe_data [LATENCY];

   // one holding slot per credit
   mem_op_e            hold_op   [LATENCY];
   logic [DATA_W-1:0]  hold_data [LATENCY];
   logic [PTR_W-1:0]   hold_wr;
   logic [PTR_W-1:0]   hold_rd;
   logic [CNT_W-1:0]   hold_cnt;
   logic [CNT_W-1:0]   credit_q;            // accepted but not yet returned

   function automatic logic [PTR_W-1:0] step(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(LATENCY - 1)) ? '0 : p + 1'b1;
   endfunction

   assign idx          = req_i.addr[IDX_W+2:3];   // word index within the bank
   assign take         = resp_valid_o && resp_ready_i;
   assign accept       = req_valid_i && req_ready_o;
   assign req_ready_o  = (credit_q < CNT_W'(LATENCY)) || take;
   assign resp_valid_o = (hold_cnt != '0);

   always_comb begin
      resp_o.status = RESP_OKAY;
      resp_o.rdata  = (hold_op[hold_rd] == OP_WRITE) ? '0 : hold_data[hold_rd];
   end

   always_ff @(posedge mig_clk) begin
      if (accept && req_i.op == OP_WRITE) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (req_i.strb[b]) begin
               ram[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
            end
         end
      end
      pipe_data[0] <= ram[idx];
      pipe_op[0]   <= req_i.op;
      for (int i = 1; i < LATENCY; i++) begin
         pipe_data[i] <= pipe_data[i-1];
         pipe_op[i]   <= pipe_op[i-1];
      end
      if (pipe_v[LATENCY-1]) begin
         hold_data[hold_wr] <= pipe_data[LATENCY-1];
         hold_op[hold_wr]   <= pipe_op[LATENCY-1];
      end
   end

   always_ff @(posedge mig_clk) begin
      if (!rst_n_i) begin
         pipe_v   <= '0;
         hold_wr  <= '0;
         hold_rd  <= '0;
         hold_cnt <= '0;
         credit_q <= '0;
      end else begin
         pipe_v[0] <= accept;
         for (int i = 1; i < LATENCY; i++) begin
            pipe_v[i] <= pipe_v[i-1];
         end
         if (pipe_v[LATENCY-1]) hold_wr <= step(hold_wr);
         if (take) hold_rd <= step(hold_rd);
         hold_cnt <= hold_cnt + CNT_W'(pipe_v[LATENCY-1]) - CNT_W'(take);
         credit_q <= credit_q + CNT_W'(accept) - CNT_W'(take);
      end
   end

endmodule

`default_nettype wire

// ==== logic/req_router.sv ====
// address decoder and in-order response mux
`timescale 1ns/100ps
`default_nettype none

module req_router #(
   parameter int BRAM_WORDS = 256,
   parameter int DRAM_WORDS = 1024
) (
   input  wire logic                    mig_clk,
   input  wire logic                    rst_n_i,
   input  wire fabric_pkg::mem_req_t    req_i,
   input  wire logic                    req_valid_i,
   output logic                         req_ready_o,
   output fabric_pkg::mem_resp_t        resp_o,
   output logic                         resp_valid_o,
   input  wire logic                    resp_ready_i,
   output fabric_pkg::mem_req_t         bram_req_o,
   output logic                         bram_req_valid_o,
   input  wire logic                    bram_req_ready_i,
   input  wire fabric_pkg::mem_resp_t   bram_resp_i,
   input  wire logic                    bram_resp_valid_i,
   output logic                         bram_resp_ready_o,
   output fabric_pkg::mem_req_t         dram_req_o,
   output logic                         dram_req_valid_o,
   input  wire logic                    dram_req_ready_i,
   input  wire fabric_pkg::mem_resp_t   dram_resp_i,
   input  wire logic                    dram_resp_valid_i,
   output logic                         dram_resp_ready_o,
   output logic                         ord_push_o,
   output fabric_pkg::mem_target_e      ord_target_o,
   input  wire logic                    ord_full_i,
   output logic                         ord_pop_o,
   input  wire fabric_pkg::mem_target_e ord_head_i,
   input  wire logic                    ord_empty_i
);
   import fabric_pkg::*;

   // region limits carry an extra bit so the top of the space cannot wrap
   localparam logic [ADDR_W:0] BRAM_END = {1'b0, BRAM_BASE} + (ADDR_W+1)'(BRAM_WORDS * 8);
   localparam logic [ADDR_W:0] DRAM_END = {1'b0, DRAM_BASE} + (ADDR_W+1)'(DRAM_WORDS * 8);

   logic [ADDR_W:0] addr_x;
   logic            en_q;        // request port opens one cycle after reset
   logic            fwd_ok;
   mem_target_e     tgt;
   logic            tgt_ready;

   always_ff @(posedge mig_clk) begin
      if (!rst_n_i) begin
         en_q <= 1'b0;
      end else begin
         en_q <= 1'b1;
      end
   end

   assign addr_x = {1'b0, req_i.addr};

   always_comb begin
      if (addr_x >= {1'b0, BRAM_BASE} && addr_x < BRAM_END) begin
         tgt = TGT_BRAM;
      end else if (addr_x >= {1'b0, DRAM_BASE} && addr_x < DRAM_END) begin
         tgt = TGT_DRAM;
      end else begin
         tgt = TGT_NONE;
      end
      case (tgt)
         TGT_BRAM: tgt_ready = bram_req_ready_i;
         TGT_DRAM: tgt_ready = dram_req_ready_i;
         default:  tgt_ready = 1'b1;   // decode error needs only a FIFO slot
      endcase
   end

   assign fwd_ok           = req_valid_i && en_q && !ord_full_i;
   assign req_ready_o      = en_q && !ord_full_i && tgt_ready;
   assign bram_req_o       = req_i;
   assign dram_req_o       = req_i;
   assign bram_req_valid_o = fwd_ok && (tgt == TGT_BRAM);
   assign dram_req_valid_o = fwd_ok && (tgt == TGT_DRAM);
   assign ord_push_o       = req_valid_i && req_ready_o;
   assign ord_target_o     = tgt;

   // head of the order FIFO picks the response source
   always_comb begin
      resp_o            = '0;
      resp_valid_o      = 1'b0;
      bram_resp_ready_o = 1'b0;
      dram_resp_ready_o = 1'b0;
      if (!ord_empty_i) begin
         case (ord_head_i)
            TGT_BRAM: begin
               resp_o            = bram_resp_i;
               resp_valid_o      = bram_resp_valid_i;
               bram_resp_ready_o = resp_ready_i;
            end
            TGT_DRAM: begin
               resp_o            = dram_resp_i;
               resp_valid_o      = dram_resp_valid_i;
               dram_resp_ready_o = resp_ready_i;
            end
            default: begin
               resp_o       = '{status: RESP_DECERR, rdata: '0};
               resp_valid_o = 1'b1;
            end
         endcase
      end
   end

   assign ord_pop_o = resp_valid_o && resp_ready_i;

endmodule

`default_nettype wire

// ==== logic/mem_fabric_top.sv ====
// memory fabric top level
`timescale 1ns/100ps
`default_nettype none

module mem_fabric_top #(
   parameter int BRAM_WORDS  = 256,
   parameter int DRAM_WORDS  = 1024,
   parameter int BRAM_LAT    = 1,
   parameter int DRAM_LAT    = 4,
   parameter int ORDER_DEPTH = 8
) (
   input  wire logic                  mig_clk,
   input  wire logic                  rst_n_i,
   input  wire fabric_pkg::mem_req_t  req_i,
   input  wire logic                  req_valid_i,
   output logic                       req_ready_o,
   output fabric_pkg::mem_resp_t      resp_o,
   output logic                       resp_valid_o,
   input  wire logic                  resp_ready_i
);
   import fabric_pkg::*;

   mem_req_t    bram_req;
   mem_req_t    dram_req;
   mem_resp_t   bram_resp;
   mem_resp_t   dram_resp;
   logic        bram_req_valid;
   logic        bram_req_ready;
   logic        bram_resp_valid;
   logic        bram_resp_ready;
   logic        dram_req_valid;
   logic        dram_req_ready;
   logic        dram_resp_valid;
   logic        dram_resp_ready;
   mem_target_e ord_target;
   mem_target_e ord_head;
   logic        ord_push;
   logic        ord_full;
   logic        ord_pop;
   logic        ord_empty;

   req_router #(.BRAM_WORDS(BRAM_WORDS), .DRAM_WORDS(DRAM_WORDS)) router (
      .*,
      .bram_req_o        ( bram_req        ),
      .bram_req_valid_o  ( bram_req_valid  ),
      .bram_req_ready_i  ( bram_req_ready  ),
      .bram_resp_i       ( bram_resp       ),
      .bram_resp_valid_i ( bram_resp_valid ),
      .bram_resp_ready_o ( bram_resp_ready ),
      .dram_req_o        ( dram_req        ),
      .dram_req_valid_o  ( dram_req_valid  ),
      .dram_req_ready_i  ( dram_req_ready  ),
      .dram_resp_i       ( dram_resp       ),
      .dram_resp_valid_i ( dram_resp_valid ),
      .dram_resp_ready_o ( dram_resp_ready ),
      .ord_push_o        ( ord_push        ),
      .ord_target_o      ( ord_target      ),
      .ord_full_i        ( ord_full        ),
      .ord_pop_o         ( ord_pop         ),
      .ord_head_i        ( ord_head        ),
      .ord_empty_i       ( ord_empty       )
   );

   // bounds the requests in flight across the fabric
   order_fifo #(.DEPTH(ORDER_DEPTH)) ord_fifo (
      .*,
      .push_i   ( ord_push   ),
      .target_i ( ord_target ),
      .full_o   ( ord_full   ),
      .pop_i    ( ord_pop    ),
      .head_o   ( ord_head   ),
      .empty_o  ( ord_empty  )
   );

   mem_bank #(.WORDS(BRAM_WORDS), .LATENCY(BRAM_LAT)) bram_bank (
      .*,
      .req_i        ( bram_req        ),
      .req_valid_i  ( bram_req_valid  ),
      .req_ready_o  ( bram_req_ready  ),
      .resp_o       ( bram_resp       ),
      .resp_valid_o ( bram_resp_valid ),
      .resp_ready_i ( bram_resp_ready )
   );

   mem_bank #(.WORDS(DRAM_WORDS), .LATENCY(DRAM_LAT)) dram_bank (   // slower window
      .*,
      .req_i        ( dram_req        ),
      .req_valid_i  ( dram_req_valid  ),
      .req_ready_o  ( dram_req_ready  ),
      .resp_o       ( dram_resp       ),
      .resp_valid_o ( dram_resp_valid ),
      .resp_ready_i ( dram_resp_ready )
   );

endmodule

`default_nettype wire

// ==== testbench/mem_fabric_properties.sv ====
// fabric handshake properties
`timescale 1ns/100ps
`default_nettype none

module mem_fabric_properties (
   input wire logic                  mig_clk,
   input wire logic                  rst_n_i,
   input wire logic                  req_ready_o,
   input wire fabric_pkg::mem_resp_t resp_o,
   input wire logic                  resp_valid_o,
   input wire logic                  resp_ready_i
);
   import fabric_pkg::*;

   int unsigned fail_cnt = 0;   // failed assertion count

   // stalled response keeps valid and payload
   resp_hold_stable: assert property (@(posedge mig_clk) disable iff (!rst_n_i)
      resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o))
      else begin
         fail_cnt++;
         $error("response changed while stalled");
      end

   req_ready_known: assert property (@(posedge mig_clk) disable iff (!rst_n_i)
      !$isunknown(req_ready_o))
      else begin
         fail_cnt++;
         $error("req_ready_o unknown after reset");
      end

   resp_idle_after_reset: assert property (@(posedge mig_clk) !rst_n_i |=> !resp_valid_o)
      else begin
         fail_cnt++;
         $error("resp_valid_o high right after reset");
      end

endmodule

`default_nettype wire

// ==== testbench/tb_mem_fabric.sv ====
// memory fabric testbench
`timescale 1ns/100ps
`default_nettype none

module tb_mem_fabric;
   import fabric_pkg::*;

   localparam int BRAM_WORDS  = 256;
   localparam int DRAM_WORDS  = 1024;
   localparam int BRAM_LAT    = 1;
   localparam int DRAM_LAT    = 4;
   localparam int ORDER_DEPTH = 8;
   localparam int CLK_NS      = 8;
   localparam int WIN         = 16;    // words exercised per region
   localparam int N_MIX       = 200;
   localparam int N_STALL     = 200;
   localparam int N_REQ       = 2 * (4 * WIN) + 4 + 16 + 2 * WIN + N_MIX + N_STALL;
   localparam int WDOG_NS     = (N_REQ * (DRAM_LAT + 20) + 500) * CLK_NS;
   localparam longint BRAM_LIMIT = BRAM_BASE + BRAM_WORDS * 8;
   localparam longint DRAM_LIMIT = DRAM_BASE + DRAM_WORDS * 8;

   logic        mig_clk;
   logic        rst_n_i;
   mem_req_t    req_i;
   logic        req_valid_i;
   logic        req_ready_o;
   mem_resp_t   resp_o;
   logic        resp_valid_o;
   logic        resp_ready_i;

   logic [DATA_W-1:0] bram_shadow [BRAM_WORDS];
   logic [DATA_W-1:0] dram_shadow [DRAM_WORDS];
   mem_resp_t   exp_q [$];
   string       name_q [$];
   string       cur_test;
   bit          stall_en;
   int unsigned n_req;
   int unsigned n_resp;
   int unsigned val_errs;
   int unsigned proto_errs;

   mem_fabric_top #(
      .BRAM_WORDS(BRAM_WORDS), .DRAM_WORDS(DRAM_WORDS), .BRAM_LAT(BRAM_LAT),
      .DRAM_LAT(DRAM_LAT), .ORDER_DEPTH(ORDER_DEPTH)
   ) uut (
      .mig_clk(mig_clk), .rst_n_i(rst_n_i),
      .req_i(req_i), .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
      .resp_o(resp_o), .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i)
   );

   bind mem_fabric_top mem_fabric_properties props (
      .mig_clk(mig_clk), .rst_n_i(rst_n_i), .req_ready_o(req_ready_o),
      .resp_o(resp_o), .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i)
   );

   initial begin
      mig_clk = 1'b0;
      forever #(CLK_NS / 2) mig_clk = ~mig_clk;
   end

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
         input logic [DATA_W-1:0] new_w, input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] w;
      w = old_w;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) w[b*8 +: 8] = new_w[b*8 +: 8];
      end
      return w;
   endfunction

   // returns the expected response and updates the shadow memory on writes
   function automatic mem_resp_t model_access(input mem_req_t req);
      mem_resp_t         rsp;
      longint unsigned   a;
      int                idx;
      logic [DATA_W-1:0] word;
      rsp = '{status: RESP_OKAY, rdata: '0};
      a = req.addr;
      if (a >= BRAM_BASE && a < BRAM_LIMIT) begin
         idx = int'((a - BRAM_BASE) / 8);
         word = bram_shadow[idx];
         if (req.op == OP_WRITE) bram_shadow[idx] = merge_bytes(word, req.wdata, req.strb);
         else rsp.rdata = word;
      end else if (a >= DRAM_BASE && a < DRAM_LIMIT) begin
         idx = int'((a - DRAM_BASE) / 8);
         word = dram_shadow[idx];
         if (req.op == OP_WRITE) dram_shadow[idx] = merge_bytes(word, req.wdata, req.strb);
         else rsp.rdata = word;
      end else begin
         rsp.status = RESP_DECERR;   // nothing stored
      end
      return rsp;
   endfunction

   function automatic mem_req_t build_req(input mem_op_e kind, input logic [ADDR_W-1:0] a,
         input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] s);
      return '{op: kind, addr: a, wdata: d, strb: s};
   endfunction

   function automatic logic [ADDR_W-1:0] region_addr(input int sel, input int word);
      return ((sel == 1) ? DRAM_BASE : BRAM_BASE) + ADDR_W'(word * 8);
   endfunction

   function automatic logic [ADDR_W-1:0] unmapped_addr();
      logic [ADDR_W-1:0] k;
      k = ADDR_W'(($urandom % WIN) * 8);
      case ($urandom % 3)
         0: return ADDR_W'(BRAM_LIMIT) + k;   // same index bits as the BRAM words
         1: return ADDR_W'(DRAM_LIMIT) + k;
         default: return 32'h8000_0000 | (ADDR_W'($urandom) & ~ADDR_W'(7));
      endcase
   endfunction

   // sel 0 bram, 1 dram, else unmapped
   function automatic mem_req_t rand_req(input int sel, input bit wr);
      logic [ADDR_W-1:0] a;
      a = (sel > 1) ? unmapped_addr() : region_addr(sel, int'($urandom % WIN));
      return build_req(wr ? OP_WRITE : OP_READ, a, {$urandom, $urandom}, STRB_W'($urandom));
   endfunction

   task automatic check_status(input string name, input resp_status_e exp,
         input resp_status_e act);
      if (act !== exp) begin
         $display("FAILED %s status: expected %s, actual %s", name, exp.name(), act.name());
         val_errs++;
      end
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
         input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("FAILED %s rdata: expected %h, actual %h", name, exp, act);
         val_errs++;
      end
   endtask

   // called on a falling edge, returns on the falling edge after the transfer
   task automatic issue(input mem_req_t r);
      req_i       <= r;
      req_valid_i <= 1'b1;
      @(posedge mig_clk);
      while (!req_ready_o) @(posedge mig_clk);
      @(negedge mig_clk);
      req_valid_i <= 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) @(negedge mig_clk);
   endtask

   task automatic region_test(input string name, input int sel);
      cur_test = name;
      for (int i = 0; i < WIN; i++) begin
         issue(build_req(OP_WRITE, region_addr(sel, i), {$urandom, $urandom}, '1));
      end
      for (int i = 0; i < 2 * WIN; i++) issue(rand_req(sel, 1'b1));
      for (int i = 0; i < WIN; i++) issue(build_req(OP_READ, region_addr(sel, i), '0, '0));
      wait_drain();
   endtask

   always @(posedge mig_clk) begin : req_monitor
      if (rst_n_i && req_valid_i && req_ready_o) begin
         exp_q.push_back(model_access(req_i));
         name_q.push_back($sformatf("%s #%0d", cur_test, n_req));
         n_req++;
      end
   end

   always @(posedge mig_clk) begin : resp_compare
      mem_resp_t exp;
      string     nm;
      if (rst_n_i && resp_valid_o && resp_ready_i) begin
         n_resp++;
         if (exp_q.size() == 0) begin
            $display("ERROR: response at %0t with no request outstanding", $time);
            proto_errs++;
         end else begin
            exp = exp_q.pop_front();
            nm  = name_q.pop_front();
            check_status(nm, exp.status, resp_o.status);
            check_data(nm, exp.rdata, resp_o.rdata);
         end
      end
   end

   initial begin : resp_stall_gen
      int hold;
      hold = 0;
      forever begin
         @(negedge mig_clk);
         if (stall_en) begin
            if (hold > 0) begin
               hold--;
               resp_ready_i <= 1'b0;
            end else if ($urandom % 16 == 0) begin
               hold = 20 + int'($urandom % 20);   // long stretch low
               resp_ready_i <= 1'b0;
            end else begin
               resp_ready_i <= 1'($urandom);
            end
         end
      end
   end

   initial begin : watchdog
      #(WDOG_NS);
      $display("ERROR: timeout after %0d ns with %0d responses outstanding", WDOG_NS,
               exp_q.size());
      $display(">>> FAIL");
      $finish;
   end

   initial begin : main_seq
      int unsigned total;
      void'($urandom(32'h3191_b06a));
      rst_n_i      = 1'b0;
      req_i        = '0;
      req_valid_i  = 1'b0;
      resp_ready_i = 1'b1;
      stall_en     = 1'b0;
      cur_test     = "reset";
      repeat (2) @(posedge mig_clk);
      @(negedge mig_clk);
      rst_n_i <= 1'b1;
      region_test("bram_strobe", 0);
      region_test("dram_strobe", 1);
      cur_test = "no_alias";
      issue(build_req(OP_WRITE, region_addr(0, 5), 64'h0123_4567_89ab_cdef, '1));
      issue(build_req(OP_WRITE, region_addr(1, 5), 64'hfedc_ba98_7654_3210, '1));
      issue(build_req(OP_READ, region_addr(0, 5), '0, '0));
      issue(build_req(OP_READ, region_addr(1, 5), '0, '0));
      cur_test = "unmapped";
      for (int i = 0; i < 8; i++) issue(rand_req(2, 1'b1));
      for (int i = 0; i < 8; i++) issue(rand_req(2, 1'b0));
      for (int i = 0; i < WIN; i++) begin   // mapped words must be untouched
         issue(build_req(OP_READ, region_addr(0, i), '0, '0));
         issue(build_req(OP_READ, region_addr(1, i), '0, '0));
      end
      wait_drain();
      cur_test = "mixed_b2b";
      for (int i = 0; i < N_MIX; i++) issue(rand_req(int'($urandom % 3), 1'($urandom)));
      wait_drain();
      cur_test = "resp_stall";
      stall_en = 1'b1;
      for (int i = 0; i < N_STALL; i++) issue(rand_req(int'($urandom % 3), 1'($urandom)));
      wait_drain();
      stall_en = 1'b0;
      @(negedge mig_clk);
      resp_ready_i <= 1'b1;
      repeat (20) @(negedge mig_clk);   // catch late extra responses
      if (n_resp != n_req) begin
         $display("ERROR: %0d requests accepted but %0d responses seen", n_req, n_resp);
         proto_errs++;
      end
      total = val_errs + proto_errs + uut.props.fail_cnt;
      $display("tb_mem_fabric: %0d requests, errors: %0d value, %0d protocol, %0d assertion",
               n_req, val_errs, proto_errs, uut.props.fail_cnt);
      if (total == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== mem_fabric.f ====
logic/fabric_pkg.sv
logic/order_fifo.sv
logic/mem_bank.sv
logic/req_router.sv
logic/mem_fabric_top.sv
testbench/mem_fabric_properties.sv
testbench/tb_mem_fabric.sv

// ==== Bender.yml ====
package:
  name: mem_fabric

sources:
  - logic/fabric_pkg.sv
  - logic/order_fifo.sv
  - logic/mem_bank.sv
  - logic/req_router.sv
  - logic/mem_fabric_top.sv
  - target: test
    files:
      - testbench/mem_fabric_properties.sv
      - testbench/tb_mem_fabric.sv
